// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // ======================================================================
    // datapath
    // ======================================================================
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;  // first fetch address

    // ======================================================================
    // branch target buffer
    // ======================================================================
    localparam int btb_entries = 32;
    localparam int btb_index_lsb = 2;
    localparam int btb_index_msb = 6;
    localparam int btb_idx_w = btb_index_msb - btb_index_lsb + 1;
    localparam logic [xlen-1:0] btb_empty_tag = 32'h0000_0001;  // odd, never an aligned pc

    // redirected fetches carry this in is[1:0]
    localparam logic [1:0] redirect_mark = 2'd2;

    // ======================================================================
    // instruction memory
    // ======================================================================
    localparam int imem_words = 256;
    localparam int imem_aw = $clog2(imem_words);
    localparam int boot_limit = 64;  // byte address, uncached below
    localparam int boot_words = boot_limit / 4;
    localparam int boot_aw = $clog2(boot_words);
    localparam int imem_latency = 3;  // rd_start to data valid
    localparam int lat_cnt_w = $clog2(imem_latency + 1);

    // word w = w * imem_step ^ imem_seed, boot byte w = boot_byte_base + w
    localparam logic [xlen-1:0] imem_seed = 32'hA500_0003;
    localparam logic [xlen-1:0] imem_step = 32'h0101_0101;
    localparam logic [7:0] boot_byte_base = 8'h40;

endpackage

// ==== fetch/btb.sv ====
module btb (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr,
    input  logic [fetch_pkg::xlen-1:0]  wr_tag,
    input  logic [fetch_pkg::xlen-1:0]  wr_target,
    input  logic [fetch_pkg::xlen-1:0]  rd_pc,
    output logic [fetch_pkg::xlen-1:0]  rd_tag,
    output logic [fetch_pkg::xlen-1:0]  rd_target
);
    import fetch_pkg::*;

    logic [xlen-1:0]      tag_mem [btb_entries];
    logic [xlen-1:0]      tgt_mem [btb_entries];
    logic [btb_idx_w-1:0] wr_idx;
    logic [btb_idx_w-1:0] rd_idx;

    assign wr_idx = wr_tag[btb_index_msb:btb_index_lsb];
    assign rd_idx = rd_pc[btb_index_msb:btb_index_lsb];

    // reset fill makes every entry a guaranteed miss
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                tag_mem[i] <= btb_empty_tag;
                tgt_mem[i] <= '0;
            end
        end else if (wr) begin
            tag_mem[wr_idx] <= wr_tag;  // full branch address as tag
            tgt_mem[wr_idx] <= wr_target;
        end
    end

    // registered lookup
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_tag    <= btb_empty_tag;
            rd_target <= '0;
        end else begin
            rd_tag    <= tag_mem[rd_idx];
            rd_target <= tgt_mem[rd_idx];
        end
    end

endmodule

// ==== fetch/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       stl,
    input  logic       done,
    output logic       rd_start,
    output logic [1:0] ok
);

    typedef enum logic [1:0] {
        st_start,  // first read after reset
        st_wait,   // read in flight
        st_next    // response seen, next read unless stalled
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic       issue;
    logic [1:0] ok_nxt;

    // ======================================================================
    // next state
    // ======================================================================
    always_comb begin
        state_nxt = state;
        issue     = 1'b0;
        case (state)
            st_start: begin
                if (!stl) begin
                    issue     = 1'b1;
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (done) begin
                    state_nxt = st_next;
                end
            end
            st_next: begin
                if (!stl) begin  // hold here for the whole stall
                    issue     = 1'b1;
                    state_nxt = st_wait;
                end
            end
            default: state_nxt = st_start;
        endcase
    end

    // token skips 0 so the stage never mistakes it for reset
    assign ok_nxt = (ok == 2'd3) ? 2'd1 : ok + 2'd1;

    // ======================================================================
    // registers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_start;
            rd_start <= 1'b0;
            ok       <= 2'd0;
        end else begin
            state    <= state_nxt;
            rd_start <= issue;  // one cycle pulse
            if (state == st_wait && done) begin
                ok <= ok_nxt;
            end
        end
    end

endmodule

// ==== fetch/fetch_stage.sv ====
module fetch_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [1:0]                  ok,
    input  logic [fetch_pkg::xlen-1:0]  dt,
    input  logic [7:0]                  rom_rn,
    input  logic                        cache_hit,
    input  logic                        ex_if_pce,
    input  logic [fetch_pkg::xlen-1:0]  ex_if_pc,
    input  logic [fetch_pkg::xlen-1:0]  bp_tag,
    input  logic [fetch_pkg::xlen-1:0]  bp_target,
    output logic [fetch_pkg::xlen-1:0]  pc,
    output logic [fetch_pkg::xlen-1:0]  is,
    output logic [fetch_pkg::xlen-1:0]  cpc,
    output logic                        if_e
);
    import fetch_pkg::*;

    logic            redir_pend;  // redirect waiting for the next if_e
    logic [xlen-1:0] redir_pc;
    logic            used;
    logic [1:0]      ok_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] is_q;
    logic [xlen-1:0] cpc_q;
    logic [xlen-1:0] pc4_q;
    logic [xlen-1:0] inst_raw;

    // boot region gets its top byte from the byte table
    assign inst_raw = cache_hit ? dt : {rom_rn, dt[23:0]};

    // ======================================================================
    // pending redirect
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            redir_pend <= 1'b0;
        end else if (ex_if_pce) begin
            redir_pend <= 1'b1;
        end else if (used) begin
            redir_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_if_pce) begin
            redir_pc <= ex_if_pc;
        end
    end

    // ======================================================================
    // held outputs
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            ok_q  <= 2'd0;
            pc_q  <= reset_pc;
            is_q  <= '0;
            cpc_q <= '0;
        end else begin
            ok_q  <= ok;
            pc_q  <= pc;
            is_q  <= is;
            cpc_q <= cpc;
        end
    end

    // pc is stable for several cycles before each if_e
    always_ff @(posedge clk) begin
        pc4_q <= pc + xlen'(4);
    end

    always_comb begin
        if_e = 1'b0;
        used = 1'b0;
        pc   = pc_q;
        is   = is_q;
        cpc  = cpc_q;
        if (ok != ok_q) begin  // new response from memory
            if_e = 1'b1;
            cpc  = pc_q;
            if (redir_pend) begin
                pc   = redir_pc;
                is   = {inst_raw[xlen-1:2], redirect_mark};
                used = 1'b1;
            end else begin
                is = inst_raw;
                if (bp_tag == pc_q) begin  // btb hit on this address
                    pc = bp_target;
                end else begin
                    pc = pc4_q;
                end
            end
        end
    end

endmodule

// ==== design/latency_timer.sv ====
module latency_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);
    import fetch_pkg::*;

    logic [lat_cnt_w-1:0] cnt;

    // The start cycle is the first of the imem_latency cycles, and done
    // comes one cycle ahead of data valid since ok is registered after it.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= lat_cnt_w'(imem_latency - 1);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;  // stops at zero
        end
    end

    assign done = (cnt == lat_cnt_w'(1));

endmodule

// ==== design/inst_mem.sv ====
module inst_mem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_start,
    input  logic [fetch_pkg::xlen-1:0]  addr,
    output logic [fetch_pkg::xlen-1:0]  dt,
    output logic [7:0]                  rom_rn,
    output logic                        cache_hit
);
    import fetch_pkg::*;

    logic [xlen-1:0]    word_mem [imem_words];
    logic [7:0]         boot_mem [boot_words];
    logic [imem_aw-1:0] widx_q;  // latched word index

    // ======================================================================
    // contents, filled at reset and read only afterwards
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < imem_words; w++) begin
                word_mem[w] <= (xlen'(w) * imem_step) ^ imem_seed;
            end
            for (int b = 0; b < boot_words; b++) begin
                boot_mem[b] <= boot_byte_base + 8'(b);
            end
        end
    end

    // ======================================================================
    // access
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            widx_q    <= '0;
            cache_hit <= 1'b0;
        end else if (rd_start) begin
            widx_q    <= addr[imem_aw+1:2];
            cache_hit <= (addr >= xlen'(boot_limit));  // boot region uncached
        end
    end

    // stable until the next rd_start
    assign dt     = word_mem[widx_q];
    assign rom_rn = boot_mem[widx_q[boot_aw-1:0]];

endmodule

// ==== design/fetch_unit.sv ====
module fetch_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stl,
    input  logic                        ex_if_pce,
    input  logic [fetch_pkg::xlen-1:0]  ex_if_pc,
    input  logic [fetch_pkg::xlen-1:0]  ex_if_opc,
    output logic [fetch_pkg::xlen-1:0]  pc,
    output logic [fetch_pkg::xlen-1:0]  is,
    output logic [fetch_pkg::xlen-1:0]  cpc,
    output logic                        if_e
);
    import fetch_pkg::*;

    logic            rd_start;
    logic            done;
    logic [1:0]      ok;
    logic [xlen-1:0] dt;
    logic [7:0]      rom_rn;
    logic            cache_hit;
    logic [xlen-1:0] bp_tag;
    logic [xlen-1:0] bp_target;

    // ======================================================================
    // memory side
    // ======================================================================
    fetch_ctrl u_fetch_ctrl (
        .clk      (clk),
        .rst      (rst),
        .stl      (stl),
        .done     (done),
        .rd_start (rd_start),
        .ok       (ok)
    );

    latency_timer u_latency_timer (
        .clk   (clk),
        .rst   (rst),
        .start (rd_start),
        .done  (done)
    );

    inst_mem u_inst_mem (
        .clk       (clk),
        .rst       (rst),
        .rd_start  (rd_start),
        .addr      (pc),  // next fetch address
        .dt        (dt),
        .rom_rn    (rom_rn),
        .cache_hit (cache_hit)
    );

    // ======================================================================
    // prediction and stage
    // ======================================================================
    btb u_btb (
        .clk       (clk),
        .rst       (rst),
        .wr        (ex_if_pce),
        .wr_tag    (ex_if_opc),
        .wr_target (ex_if_pc),
        .rd_pc     (pc),
        .rd_tag    (bp_tag),
        .rd_target (bp_target)
    );

    fetch_stage u_fetch_stage (
        .clk       (clk),
        .rst       (rst),
        .ok        (ok),
        .dt        (dt),
        .rom_rn    (rom_rn),
        .cache_hit (cache_hit),
        .ex_if_pce (ex_if_pce),
        .ex_if_pc  (ex_if_pc),
        .bp_tag    (bp_tag),
        .bp_target (bp_target),
        .pc        (pc),
        .is        (is),
        .cpc       (cpc),
        .if_e      (if_e)
    );

endmodule

// ==== verif/fetch_unit_tb.sv ====
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    typedef struct packed {
        logic            stl_lvl;
        logic [7:0]      stl_len;
        logic            redir;
        logic [xlen-1:0] opc;
        logic [xlen-1:0] tgt;
        logic [7:0]      gap;  // cycles since the previous if_e
        logic [xlen-1:0] exp_cpc;
        logic [xlen-1:0] exp_pc;
        logic [xlen-1:0] exp_is;
    } row_t;

    localparam int wait_limit = 20;

    logic            clk;
    logic            rst;
    logic            stl;
    logic            ex_if_pce;
    logic [xlen-1:0] ex_if_pc;
    logic [xlen-1:0] ex_if_opc;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] is;
    logic [xlen-1:0] cpc;
    logic            if_e;

    row_t            rows[$];
    int              seed = 32'he18;
    int              stall_left;
    logic            stall_lvl;
    logic [xlen-1:0] held_pc;
    logic [xlen-1:0] held_is;
    logic [xlen-1:0] held_cpc;

    fetch_unit u_fetch_unit (
        .clk       (clk),
        .rst       (rst),
        .stl       (stl),
        .ex_if_pce (ex_if_pce),
        .ex_if_pc  (ex_if_pc),
        .ex_if_opc (ex_if_opc),
        .pc        (pc),
        .is        (is),
        .cpc       (cpc),
        .if_e      (if_e)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // compare tasks
    // ======================================================================
    task automatic check_addr(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_inst(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "strobe mismatch");
        end
    endtask

    // ======================================================================
    // stimulus table and reference model
    // ======================================================================
    task automatic add_row(input logic stl_lvl, input int stl_len, input logic redir,
                           input logic [xlen-1:0] opc, input logic [xlen-1:0] tgt);
        row_t r;
        r         = '0;
        r.stl_lvl = stl_lvl;
        r.stl_len = 8'(stl_len);
        r.redir   = redir;
        r.opc     = opc;
        r.tgt     = tgt;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [xlen-1:0] opc;
        logic [xlen-1:0] tgt;
        repeat (20) add_row(1'b0, 0, 1'b0, '0, '0);  // boot region into cached words
        add_row(1'b0, 0, 1'b1, 32'h0000_0058, 32'h0000_0044);  // backward branch
        repeat (7) add_row(1'b0, 0, 1'b0, '0, '0);  // 0x58 hits the btb
        add_row(1'b1, 9, 1'b0, '0, '0);  // outlasts the in-flight read
        repeat (2) add_row(1'b0, 0, 1'b0, '0, '0);
        add_row(1'b1, 2, 1'b0, '0, '0);
        add_row(1'b1, 6, 1'b1, 32'h0000_0100, 32'h0000_0010);
        repeat (3) add_row(1'b0, 0, 1'b0, '0, '0);
        for (int i = 0; i < 8; i++) begin
            opc = $random(seed) & 32'h0000_03fc;
            tgt = $random(seed) & 32'h0000_03fc;  // aligned, inside memory
            add_row(1'b0, 0, 1'b1, opc, tgt);
            repeat (2) add_row(1'b0, 0, 1'b0, '0, '0);
        end
    endtask

    function automatic logic [xlen-1:0] model_inst(input logic [xlen-1:0] addr);
        logic [xlen-1:0] w;
        logic [xlen-1:0] word;
        w    = (addr >> 2) % imem_words;
        word = (w * imem_step) ^ imem_seed;
        if (addr >= boot_limit) begin
            return word;
        end else begin
            return {boot_byte_base + w[7:0], word[23:0]};  // boot byte on top
        end
    endfunction

    function automatic void fill_expected();
        logic [xlen-1:0] btb_tag [btb_entries];
        logic [xlen-1:0] btb_tgt [btb_entries];
        logic [xlen-1:0] cur;
        logic [xlen-1:0] pend_tgt;
        logic            pend;
        row_t            r;
        int              t_prev;
        int              stl_from;
        int              stl_to;
        int              s;
        int              idx;
        for (int i = 0; i < btb_entries; i++) begin
            btb_tag[i] = btb_empty_tag;
            btb_tgt[i] = '0;
        end
        cur      = reset_pc;
        pend     = 1'b0;
        pend_tgt = '0;
        t_prev   = 0;  // reset release cycle acts as the previous strobe
        stl_from = 1;
        stl_to   = 0;
        for (int k = 0; k < rows.size(); k++) begin
            r = rows[k];
            if (r.stl_len != 0) begin
                stl_from = t_prev + 1;
                stl_to   = r.stl_lvl ? t_prev + int'(r.stl_len) : t_prev;
            end
            s = t_prev + 1;  // read starts once stl was low the cycle before
            while (s - 1 >= stl_from && s - 1 <= stl_to) begin
                s++;
            end
            r.gap  = 8'(s + imem_latency - t_prev);
            t_prev = s + imem_latency;
            if (r.redir) begin
                idx          = int'(r.opc[btb_index_msb:btb_index_lsb]);
                btb_tag[idx] = r.opc;
                btb_tgt[idx] = r.tgt;
                pend         = 1'b1;
                pend_tgt     = r.tgt;
            end
            r.exp_cpc = cur;
            r.exp_is  = model_inst(cur);
            idx       = int'(cur[btb_index_msb:btb_index_lsb]);
            if (pend) begin
                r.exp_is[1:0] = redirect_mark;
                cur           = pend_tgt;
                pend          = 1'b0;
            end else if (btb_tag[idx] == cur) begin
                cur = btb_tgt[idx];
            end else begin
                cur = cur + 32'd4;
            end
            r.exp_pc = cur;
            rows[k]  = r;
        end
    endfunction

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        row_t r;
        int   waited;
        logic seen;
        rst        = 1'b1;
        stl        = 1'b0;
        ex_if_pce  = 1'b0;
        ex_if_pc   = '0;
        ex_if_opc  = '0;
        stall_left = 0;
        stall_lvl  = 1'b0;
        held_pc    = '0;
        held_is    = '0;
        held_cpc   = '0;
        build_table();
        fill_expected();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_strobe(if_e, 1'b0, "if_e after reset");
        for (int k = 0; k < rows.size(); k++) begin
            r = rows[k];
            if (r.stl_len != 0) begin
                stall_left = int'(r.stl_len);
                stall_lvl  = r.stl_lvl;
            end
            waited = 0;
            seen   = 1'b0;
            while (!seen) begin
                @(posedge clk);
                #1;
                stl = (stall_left > 0) ? stall_lvl : 1'b0;
                if (stall_left > 0) begin
                    stall_left--;
                end
                ex_if_pce = (waited == 0) ? r.redir : 1'b0;  // one cycle pulse
                ex_if_opc = r.opc;
                ex_if_pc  = r.tgt;
                waited++;
                @(negedge clk);
                check_strobe(if_e, waited == int'(r.gap), "if_e");
                if (if_e) begin
                    seen = 1'b1;
                end else begin
                    check_addr(pc, held_pc, "held pc");
                    check_addr(cpc, held_cpc, "held cpc");
                    check_inst(is, held_is, "held is");
                    if (waited >= wait_limit) begin
                        $display("Fetch strobe never arrived within %0d cycles", wait_limit);
                        $display("Testbench failed");
                        $fatal(1, "timeout");
                    end
                end
            end
            check_addr(cpc, r.exp_cpc, "cpc");
            check_addr(pc, r.exp_pc, "pc");
            check_inst(is, r.exp_is, "is");
            held_pc  = r.exp_pc;
            held_cpc = r.exp_cpc;
            held_is  = r.exp_is;
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== build.f ====
common/fetch_pkg.sv
fetch/btb.sv
fetch/fetch_ctrl.sv
fetch/fetch_stage.sv
design/latency_timer.sv
design/inst_mem.sv
design/fetch_unit.sv
verif/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module fetch_unit_tb \
    -Mdir obj_dir -o fetch_unit_sim > compile.log 2>&1
if [ $? -ne 0 ]; then
    cat compile.log
    echo "compile failed, see compile.log"
    exit 1
fi

./obj_dir/fetch_unit_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "simulation passed"
exit 0
